// File: src/core_pkg.sv
// core-wide widths, reset PC and instruction memory sizing shared by every stage and the top
package core_pkg;

  // architectural register and data width
  localparam int xlen = 64;

  // every instruction is one 32-bit word
  localparam int ilen = 32;

  // 32 integer registers
  localparam int reg_id_w = 5;

  // first PC after reset
  localparam logic [xlen-1:0] pc_reset = 64'h0000_0000_8000_0000;

  // instruction memory in words
  localparam int imem_depth = 256;

  // word address into instruction memory
  // pc bits above the byte offset
  localparam int imem_aw = 8;

endpackage

// File: src/isa_pkg.sv
// RV64I encodings and instruction field positions used by decode and execute
package isa_pkg;

  // field widths
  localparam int opcode_w = 7;
  localparam int funct3_w = 3;
  localparam int funct7_w = 7;

  // field lsb positions inside the instruction word
  localparam int opcode_lsb = 0;
  localparam int rd_lsb = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int funct7_lsb = 25;

  // major opcodes of the supported subset
  localparam logic [opcode_w-1:0] op_imm = 7'b0010011;
  localparam logic [opcode_w-1:0] op_reg = 7'b0110011;
  localparam logic [opcode_w-1:0] op_auipc = 7'b0010111;
  localparam logic [opcode_w-1:0] op_jal = 7'b1101111;
  localparam logic [opcode_w-1:0] op_store = 7'b0100011;
  localparam logic [opcode_w-1:0] op_system = 7'b1110011;

  // function codes
  localparam logic [funct3_w-1:0] funct3_add = 3'b000;
  localparam logic [funct3_w-1:0] funct3_sd = 3'b011;
  // add, not sub
  localparam logic [funct7_w-1:0] funct7_base = 7'b0000000;

  // only one system encoding is accepted
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  // result select in execute
  typedef enum logic [1:0] {
    alu_pass = 2'd0,  // operand 2 straight through
    alu_add  = 2'd1,  // operand 1 plus operand 2
    alu_link = 2'd2   // pc plus 4
  } alu_op_e;

endpackage

// File: src/fetch_stage.sv
// fetch stage: issue PC, loadable instruction memory with synchronous read, redirect handling
`timescale 1ns/1ns

module fetch_stage (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        run,
  input  logic                        halt,
  input  logic                        redirect,
  input  logic [core_pkg::xlen-1:0]   redirect_pc,
  input  logic                        imem_we,
  input  logic [core_pkg::imem_aw-1:0] imem_addr,
  input  logic [core_pkg::ilen-1:0]   imem_wdata,
  output logic                        f_valid,
  output logic [core_pkg::xlen-1:0]   f_pc,
  output logic [core_pkg::ilen-1:0]   f_inst
);

  // pc being issued to memory this cycle
  logic [core_pkg::xlen-1:0] pc_q;
  logic [core_pkg::ilen-1:0] imem [core_pkg::imem_depth];
  logic [core_pkg::imem_aw-1:0] rd_idx;
  logic issue;

  // fetch only while enabled and not stopped
  assign issue = run & ~halt;

  // word index, byte offset dropped
  assign rd_idx = pc_q[2 +: core_pkg::imem_aw];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q    <= core_pkg::pc_reset;
      f_valid <= 1'b0;
    end else begin
      // redirect wins even with run low so a resumed run lands on the target
      if (redirect) begin
        pc_q <= redirect_pc;
      end else if (issue) begin
        pc_q <= pc_q + core_pkg::xlen'(4);
      end
      // word read this cycle is stale on redirect
      f_valid <= issue & ~redirect;
    end
  end

  always_ff @(posedge clk) begin
    // load port only open while the core is idle
    if (imem_we && !run) begin
      imem[imem_addr] <= imem_wdata;
    end
    f_inst <= imem[rd_idx];
    f_pc   <= pc_q;
  end

endmodule

// File: src/register_file.sv
// 32 x 64-bit integer register file with x0 hardwired and same-cycle write-through
`timescale 1ns/1ns

module register_file (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [core_pkg::reg_id_w-1:0] rs1_id,
  input  logic [core_pkg::reg_id_w-1:0] rs2_id,
  input  logic                          wb_en,
  input  logic [core_pkg::reg_id_w-1:0] wb_rd,
  input  logic [core_pkg::xlen-1:0]     wb_data,
  output logic [core_pkg::xlen-1:0]     rs1_data,
  output logic [core_pkg::xlen-1:0]     rs2_data
);

  // x1 to x31, x0 has no storage
  logic [core_pkg::xlen-1:0] regs [1:31];
  logic wr_live;

  // writes to x0 are dropped
  assign wr_live = wb_en && (wb_rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // bypass lets decode see the execute result in the same cycle
  always_comb begin
    if (rs1_id == '0) begin
      rs1_data = '0;
    end else if (wr_live && (wb_rd == rs1_id)) begin
      rs1_data = wb_data;
    end else begin
      rs1_data = regs[rs1_id];
    end
  end

  always_comb begin
    if (rs2_id == '0) begin
      rs2_data = '0;
    end else if (wr_live && (wb_rd == rs2_id)) begin
      rs2_data = wb_data;
    end else begin
      rs2_data = regs[rs2_id];
    end
  end

endmodule

// File: src/decode_stage.sv
// decode stage between fetch and execute that classifies the instruction and reads its registers
`timescale 1ns/1ns

module decode_stage (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          redirect,
  input  logic                          halt,
  input  logic                          f_valid,
  input  logic [core_pkg::xlen-1:0]     f_pc,
  input  logic [core_pkg::ilen-1:0]     f_inst,
  input  logic [core_pkg::xlen-1:0]     rs1_data,
  input  logic [core_pkg::xlen-1:0]     rs2_data,
  output logic [core_pkg::reg_id_w-1:0] rs1_id,
  output logic [core_pkg::reg_id_w-1:0] rs2_id,
  output logic                          d_valid,
  output logic [core_pkg::xlen-1:0]     d_pc,
  output logic [core_pkg::reg_id_w-1:0] d_rd,
  output logic [core_pkg::xlen-1:0]     d_imm,
  output logic [core_pkg::xlen-1:0]     d_rs1_data,
  output logic [core_pkg::xlen-1:0]     d_rs2_data,
  output isa_pkg::alu_op_e              d_alu_op,
  output logic                          d_use_imm,
  output logic                          d_use_pc,
  output logic                          d_reg_wen,
  output logic                          d_store,
  output logic                          d_ebreak,
  output logic                          d_illegal
);

  logic [isa_pkg::opcode_w-1:0] opcode;
  logic [isa_pkg::funct3_w-1:0] funct3;
  logic [isa_pkg::funct7_w-1:0] funct7;
  logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_u, imm_j, imm;
  isa_pkg::alu_op_e alu_op;
  logic use_imm, use_pc, reg_wen, store, ebreak, illegal;

  // instruction fields
  assign opcode = f_inst[isa_pkg::opcode_lsb +: isa_pkg::opcode_w];
  assign funct3 = f_inst[isa_pkg::funct3_lsb +: isa_pkg::funct3_w];
  assign funct7 = f_inst[isa_pkg::funct7_lsb +: isa_pkg::funct7_w];
  assign rs1_id = f_inst[isa_pkg::rs1_lsb +: core_pkg::reg_id_w];
  assign rs2_id = f_inst[isa_pkg::rs2_lsb +: core_pkg::reg_id_w];

  // sign-extended immediates per format
  assign imm_i = {{52{f_inst[31]}}, f_inst[31:20]};
  assign imm_s = {{52{f_inst[31]}}, f_inst[31:25], f_inst[11:7]};
  assign imm_u = {{32{f_inst[31]}}, f_inst[31:12], 12'b0};
  assign imm_j = {{43{f_inst[31]}}, f_inst[31], f_inst[19:12], f_inst[20], f_inst[30:21], 1'b0};

  always_comb begin
    alu_op  = isa_pkg::alu_pass;
    imm     = imm_i;
    use_imm = 1'b0;
    use_pc  = 1'b0;
    reg_wen = 1'b0;
    store   = 1'b0;
    ebreak  = 1'b0;
    illegal = 1'b0;
    case (opcode)
      isa_pkg::op_imm: begin
        // addi only
        alu_op  = isa_pkg::alu_add;
        use_imm = 1'b1;
        reg_wen = 1'b1;
        illegal = (funct3 != isa_pkg::funct3_add);
      end
      isa_pkg::op_reg: begin
        // sub shares funct3 so funct7 picks add
        alu_op  = isa_pkg::alu_add;
        reg_wen = 1'b1;
        illegal = (funct3 != isa_pkg::funct3_add) || (funct7 != isa_pkg::funct7_base);
      end
      isa_pkg::op_auipc: begin
        imm     = imm_u;
        alu_op  = isa_pkg::alu_add;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        reg_wen = 1'b1;
      end
      isa_pkg::op_jal: begin
        // adder forms the target while the result is the link
        imm     = imm_j;
        alu_op  = isa_pkg::alu_link;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        reg_wen = 1'b1;
      end
      isa_pkg::op_store: begin
        imm     = imm_s;
        use_imm = 1'b1;
        store   = (funct3 == isa_pkg::funct3_sd);
        illegal = (funct3 != isa_pkg::funct3_sd);
      end
      isa_pkg::op_system: begin
        ebreak  = (f_inst == isa_pkg::ebreak_word);
        illegal = (f_inst != isa_pkg::ebreak_word);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // valid bit dropped on redirect or stop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_valid & ~redirect & ~halt;
    end
  end

  // payload qualified by d_valid downstream
  always_ff @(posedge clk) begin
    d_pc       <= f_pc;
    d_rd       <= f_inst[isa_pkg::rd_lsb +: core_pkg::reg_id_w];
    d_imm      <= imm;
    d_rs1_data <= rs1_data;
    d_rs2_data <= rs2_data;
    d_alu_op   <= alu_op;
    d_use_imm  <= use_imm;
    d_use_pc   <= use_pc;
    d_reg_wen  <= reg_wen;
    d_store    <= store;
    d_ebreak   <= ebreak;
    d_illegal  <= illegal;
  end

endmodule

// File: src/execute_stage.sv
// execute stage: adder, write-back, jal redirect, store request and sticky halt/illegal flags
`timescale 1ns/1ns

module execute_stage (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          d_valid,
  input  logic [core_pkg::xlen-1:0]     d_pc,
  input  logic [core_pkg::reg_id_w-1:0] d_rd,
  input  logic [core_pkg::xlen-1:0]     d_imm,
  input  logic [core_pkg::xlen-1:0]     d_rs1_data,
  input  logic [core_pkg::xlen-1:0]     d_rs2_data,
  input  isa_pkg::alu_op_e              d_alu_op,
  input  logic                          d_use_imm,
  input  logic                          d_use_pc,
  input  logic                          d_reg_wen,
  input  logic                          d_store,
  input  logic                          d_ebreak,
  input  logic                          d_illegal,
  output logic                          wb_en,
  output logic [core_pkg::reg_id_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]     wb_data,
  output logic                          redirect,
  output logic [core_pkg::xlen-1:0]     redirect_pc,
  output logic                          halt,
  output logic                          illegal,
  output logic                          retire,
  output logic [core_pkg::xlen-1:0]     retire_pc,
  output logic [core_pkg::reg_id_w-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0]     retire_data,
  output logic                          store_valid,
  output logic [core_pkg::xlen-1:0]     store_addr,
  output logic [core_pkg::xlen-1:0]     store_data
);

  logic [core_pkg::xlen-1:0] op1, op2, sum, result;
  logic halt_q, illegal_q;
  logic live, exec_ok;

  // nothing executes once a flag is up
  assign live    = d_valid & ~halt_q & ~illegal_q;
  assign exec_ok = live & ~d_ebreak & ~d_illegal;

  // operand select and the single adder
  assign op1 = d_use_pc ? d_pc : d_rs1_data;
  assign op2 = d_use_imm ? d_imm : d_rs2_data;
  assign sum = op1 + op2;

  always_comb begin
    case (d_alu_op)
      isa_pkg::alu_add:  result = sum;
      isa_pkg::alu_link: result = d_pc + core_pkg::xlen'(4);
      default:           result = op2;
    endcase
  end

  // write-back into the register file
  assign wb_en   = exec_ok & d_reg_wen;
  assign wb_rd   = d_rd;
  assign wb_data = result;

  // jal target comes out of the adder as pc plus imm
  assign redirect    = exec_ok & (d_alu_op == isa_pkg::alu_link);
  assign redirect_pc = sum;

  // sd address is rs1 plus imm
  assign store_valid = exec_ok & d_store;
  assign store_addr  = sum;
  assign store_data  = d_rs2_data;

  // stores leave through the store port instead of retire
  assign retire      = exec_ok & ~d_store;
  assign retire_pc   = d_pc;
  assign retire_rd   = d_reg_wen ? d_rd : '0;
  assign retire_data = result;

  // flags rise in the cycle the instruction reaches execute
  assign halt    = halt_q | (live & d_ebreak);
  assign illegal = illegal_q | (live & d_illegal);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      halt_q    <= halt;
      illegal_q <= illegal;
    end
  end

endmodule

// File: src/rv_core_top.sv
// RV64I three-stage core top: fetch, decode, register file and execute wired to the pins
`timescale 1ns/1ns

module rv_core_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          run,
  input  logic                          imem_we,
  input  logic [core_pkg::imem_aw-1:0]  imem_addr,
  input  logic [core_pkg::ilen-1:0]     imem_wdata,
  output logic                          retire,
  output logic [core_pkg::xlen-1:0]     retire_pc,
  output logic [core_pkg::reg_id_w-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0]     retire_data,
  output logic                          store_valid,
  output logic [core_pkg::xlen-1:0]     store_addr,
  output logic [core_pkg::xlen-1:0]     store_data,
  output logic                          halt,
  output logic                          illegal
);

  // fetch to decode
  logic f_valid;
  logic [core_pkg::xlen-1:0] f_pc;
  logic [core_pkg::ilen-1:0] f_inst;
  // decode and register file
  logic [core_pkg::reg_id_w-1:0] rs1_id, rs2_id;
  logic [core_pkg::xlen-1:0] rs1_data, rs2_data;
  // decode to execute
  logic d_valid, d_use_imm, d_use_pc, d_reg_wen, d_store, d_ebreak, d_illegal;
  logic [core_pkg::xlen-1:0] d_pc, d_imm, d_rs1_data, d_rs2_data;
  logic [core_pkg::reg_id_w-1:0] d_rd;
  isa_pkg::alu_op_e d_alu_op;
  // execute back to earlier stages
  logic wb_en, redirect;
  logic [core_pkg::reg_id_w-1:0] wb_rd;
  logic [core_pkg::xlen-1:0] wb_data, redirect_pc;

  // either flag stops the front end
  fetch_stage u_fetch (
    .clk, .arst_n, .run,
    .halt        (halt | illegal),
    .redirect, .redirect_pc,
    .imem_we, .imem_addr, .imem_wdata,
    .f_valid, .f_pc, .f_inst
  );

  decode_stage u_decode (
    .clk, .arst_n, .redirect,
    .halt        (halt | illegal),
    .f_valid, .f_pc, .f_inst,
    .rs1_data, .rs2_data, .rs1_id, .rs2_id,
    .d_valid, .d_pc, .d_rd, .d_imm, .d_rs1_data, .d_rs2_data, .d_alu_op,
    .d_use_imm, .d_use_pc, .d_reg_wen, .d_store, .d_ebreak, .d_illegal
  );

  register_file u_regfile (
    .clk, .arst_n, .rs1_id, .rs2_id,
    .wb_en, .wb_rd, .wb_data,
    .rs1_data, .rs2_data
  );

  execute_stage u_execute (
    .clk, .arst_n,
    .d_valid, .d_pc, .d_rd, .d_imm, .d_rs1_data, .d_rs2_data, .d_alu_op,
    .d_use_imm, .d_use_pc, .d_reg_wen, .d_store, .d_ebreak, .d_illegal,
    .wb_en, .wb_rd, .wb_data, .redirect, .redirect_pc, .halt, .illegal,
    .retire, .retire_pc, .retire_rd, .retire_data,
    .store_valid, .store_addr, .store_data
  );

endmodule

// File: verif/tb_clock_gen.sv
// testbench clock and reset source: 40 ns clock, 8-cycle active-low reset, restartable on request
`timescale 1ns/1ns

module tb_clock_gen (
  input  logic restart,
  output logic clk,
  output logic arst_n
);

  localparam int half_period_ns = 20;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // reset from time zero, again on each restart pulse
  initial begin
    arst_n = 1'b0;
    forever begin
      repeat (reset_cycles) @(posedge clk);
      // release lines up with the input drive delay
      #1;
      arst_n = 1'b1;
      @(posedge restart);
      arst_n = 1'b0;
    end
  end

endmodule

// File: verif/rv_core_asserts.sv
// concurrent checks on the core top level pins, attached to rv_core_top by bind from the testbench
`timescale 1ns/1ns

module rv_core_asserts (
  input logic clk,
  input logic arst_n,
  input logic retire,
  input logic store_valid,
  input logic halt,
  input logic illegal
);

  // flags are sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halt |=> halt)
    else $error("halt dropped while the core was out of reset");

  illegal_sticky: assert property (@(posedge clk) disable iff (!arst_n) illegal |=> illegal)
    else $error("illegal dropped while the core was out of reset");

  // one instruction per cycle leaves execute
  retire_or_store: assert property (@(posedge clk) disable iff (!arst_n)
    !(retire && store_valid))
    else $error("retire and store_valid pulsed in the same cycle");

  // stopped core retires nothing
  quiet_when_stopped: assert property (@(posedge clk) disable iff (!arst_n)
    !(retire && (halt || illegal)))
    else $error("retire pulsed while halt or illegal was high");

endmodule

// File: verif/rv_core_tb.sv
// simulation top that runs every program of the input file on the core and checks the outputs
`timescale 1ns/1ns

module rv_core_tb;

  logic clk, arst_n, restart;
  logic run, imem_we;
  logic [core_pkg::imem_aw-1:0] imem_addr;
  logic [core_pkg::ilen-1:0] imem_wdata;
  logic retire, store_valid, halt, illegal;
  logic [core_pkg::xlen-1:0] retire_pc, retire_data, store_addr, store_data;
  logic [core_pkg::reg_id_w-1:0] retire_rd;

  // records of the program in flight
  logic [core_pkg::imem_aw-1:0] p_addr [$];
  logic [core_pkg::ilen-1:0] p_word [$];
  logic [core_pkg::xlen-1:0] r_pc [$], r_data [$], s_addr [$], s_data [$];
  logic [core_pkg::reg_id_w-1:0] r_rd [$];
  logic [7:0] exp_flag;

  int fd, err_count, check_count, prog_count, failed_progs;
  int wait_cycles, wait_limit;
  logic waiting;

  tb_clock_gen clk_gen0 (.restart, .clk, .arst_n);

  rv_core_top dut0 (
    .clk, .arst_n, .run, .imem_we, .imem_addr, .imem_wdata,
    .retire, .retire_pc, .retire_rd, .retire_data,
    .store_valid, .store_addr, .store_data, .halt, .illegal
  );

  bind rv_core_top rv_core_asserts asserts0 (.*);

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("[FAIL] t=%0t ns %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // pulls records up to the next H or I line and clears found at end of file
  task automatic read_program(output bit found);
    int code;
    bit done;
    logic [7:0] tag;
    logic [63:0] a, b, c;
    logic [8*160-1:0] junk;
    found = 1'b0;
    done = 1'b0;
    p_addr.delete();
    p_word.delete();
    r_pc.delete();
    r_rd.delete();
    r_data.delete();
    s_addr.delete();
    s_data.delete();
    while (!done) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (tag)
          "#": code = $fgets(junk, fd);
          "P": begin
            code = $fscanf(fd, "%h %h", a, b);
            p_addr.push_back(a[core_pkg::imem_aw-1:0]);
            p_word.push_back(b[core_pkg::ilen-1:0]);
          end
          "R": begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            r_pc.push_back(a);
            r_rd.push_back(b[core_pkg::reg_id_w-1:0]);
            r_data.push_back(c);
          end
          "S": begin
            code = $fscanf(fd, "%h %h", a, b);
            s_addr.push_back(a);
            s_data.push_back(b);
          end
          "H", "I": begin
            exp_flag = tag;
            found = 1'b1;
            done = 1'b1;
          end
          default: code = 0;
        endcase
        assert (code > 0) else begin
          $display("input file has a malformed or unknown record starting with '%c'", tag);
          err_count++;
        end
      end
    end
    assert (found || p_addr.size() == 0) else begin
      $display("input file ends with program words but no H or I record");
      err_count++;
    end
  endtask

  task automatic load_program();
    int idle;
    foreach (p_addr[i]) begin
      // random idle cycles between load writes
      idle = $urandom % 3;
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      imem_we = 1'b1;
      imem_addr = p_addr[i];
      imem_wdata = p_word[i];
      @(posedge clk);
      #1;
      imem_we = 1'b0;
    end
  endtask

  task automatic run_program(input int prog);
    int err_start;
    err_start = err_count;
    if (prog > 1) begin
      // fresh reset leaves the memory words in place
      restart = 1'b1;
      wait (arst_n == 1'b0);
      restart = 1'b0;
    end
    wait (arst_n == 1'b1);
    @(posedge clk);
    #1;
    load_program();
    run = 1'b1;
    wait_limit = 4 * p_addr.size() + 100;
    waiting = 1'b1;
    wait (halt || illegal);
    waiting = 1'b0;
    // extra cycles so a stray retire after the flag is seen
    repeat (4) @(posedge clk);
    #1;
    run = 1'b0;
    check_count++;
    assert (r_pc.size() == 0 && s_addr.size() == 0) else begin
      $display("program %0d stopped with %0d retires and %0d stores still expected",
               prog, r_pc.size(), s_addr.size());
      err_count++;
    end
    check_value("halt", halt, exp_flag == "H");
    check_value("illegal", illegal, exp_flag == "I");
    if (err_count != err_start) begin
      failed_progs++;
    end
    $display("program %0d, expected flag %c: %0d errors, %s", prog, exp_flag,
             err_count - err_start, (err_count == err_start) ? "ok" : "failed");
  endtask

  // retire and store pulses are compared in order at the falling edge
  always @(negedge clk) begin
    if (arst_n && retire) begin
      check_count++;
      assert (r_pc.size() > 0) else begin
        $display("t=%0t ns retire of pc %h when no retire was expected", $time, retire_pc);
        err_count++;
      end
      if (r_pc.size() > 0) begin
        check_value("retire_pc", retire_pc, r_pc.pop_front());
        check_value("retire_rd", retire_rd, r_rd[0]);
        // data only matters when a register is written
        if (r_rd.pop_front() != '0) begin
          check_value("retire_data", retire_data, r_data[0]);
        end
        void'(r_data.pop_front());
      end
    end
    if (arst_n && store_valid) begin
      check_count++;
      assert (s_addr.size() > 0) else begin
        $display("t=%0t ns store to %h when no store was expected", $time, store_addr);
        err_count++;
      end
      if (s_addr.size() > 0) begin
        check_value("store_addr", store_addr, s_addr.pop_front());
        check_value("store_data", store_data, s_data.pop_front());
      end
    end
  end

  // watchdog on the wait for halt or illegal
  always @(posedge clk) begin
    if (!waiting) begin
      wait_cycles = 0;
    end else if (wait_cycles < wait_limit) begin
      wait_cycles = wait_cycles + 1;
    end else begin
      $display("timeout: program %0d raised neither halt nor illegal within %0d cycles",
               prog_count, wait_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    bit more;
    restart = 1'b0;
    run = 1'b0;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    waiting = 1'b0;
    wait_cycles = 0;
    wait_limit = 0;
    err_count = 0;
    check_count = 0;
    prog_count = 0;
    failed_progs = 0;
    void'($urandom(54));
    fd = $fopen("verif/program_input.txt", "r");
    check_count++;
    assert (fd != 0) else begin
      $display("could not open verif/program_input.txt for reading");
      err_count++;
    end
    if (fd != 0) begin
      read_program(more);
      while (more) begin
        prog_count++;
        run_program(prog_count);
        read_program(more);
      end
      $fclose(fd);
    end
    check_count++;
    assert (prog_count > 0) else begin
      $display("input file holds no complete program");
      err_count++;
    end
    $display("programs %0d, failing %0d, checks %0d, errors %0d",
             prog_count, failed_progs, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verif/program_input.txt
# P word_index instruction | R pc rd data | S addr data | H or I ends a program with that flag
# all values hex, R and S records in the order the core must produce them
# program 1: addi/add chain, auipc, write to x0, jal over two words, sd, ebreak
P 00 00500093
P 01 00708113
P 02 002081b3
P 03 003181b3
P 04 00001217
P 05 00908013
P 06 001002b3
P 07 00c0036f
P 08 00100393
P 09 00200393
P 0a 0032b423
P 0b 00430413
P 0c 00100073
P 0d 00100493
R 80000000 1 5
R 80000004 2 c
R 80000008 3 11
R 8000000c 3 22
R 80000010 4 80001010
R 80000014 0 e
R 80000018 5 5
R 8000001c 6 80000020
R 8000002c 8 80000024
S d 22
H
# program 2: one addi, then a load opcode which the core does not implement
P 00 00300093
P 01 00003083
P 02 00100113
R 80000000 1 3
I

// File: files.f
src/core_pkg.sv
src/isa_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_core_top.sv
verif/tb_clock_gen.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/core_pkg.sv
  - src/isa_pkg.sv
  - src/fetch_stage.sv
  - src/register_file.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/rv_core_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/rv_core_asserts.sv
      - verif/rv_core_tb.sv
